// ==== mlp_defines.svh ====
`ifndef MLP_DEFINES_SVH
`define MLP_DEFINES_SVH

// Word widths of the datapath
`define DATA_W 8
`define WEIGHT_W 8
`define PROD_W 16
`define ACC_W 20

// The accumulator holds FRAC_BITS fraction bits
`define FRAC_BITS 5
`define ACT_MAX 127

// Network shape
`define N_IN 10
`define N_HID 4
`define N_OUT 3

// Pipeline depths in clock cycles
`define NODE_LAT 3
`define ARGMAX_LAT 1

// Two node layers and the argmax stage
`define TOTAL_LAT (2 * `NODE_LAT + `ARGMAX_LAT)

`endif

// ==== mlp_weights.svh ====
`ifndef MLP_WEIGHTS_SVH
`define MLP_WEIGHTS_SVH

// Weight i of node j sits in byte (j * inputs + i), so node 0 input 0 is
// the lowest byte. Every value is a signed 8-bit number
// with the binary point FRAC_BITS places from the right.
// Each row below is one node, written from its last input down to input 0.

// Hidden layer, ten features into four nodes
`define HID_W { \
	80'h1A_16_12_0E_0A_06_02_FE_FA_F6, \
	80'hF4_0C_F4_0C_F4_0C_F4_0C_F4_0C, \
	80'hEE_F4_06_0E_16_16_0E_06_F4_EE, \
	80'h08_EC_F1_F6_FB_00_05_0A_0F_14 \
}

// Biases of hidden nodes 3 down to 0
`define HID_B { \
	8'hFA, \
	8'h02, \
	8'hFD, \
	8'h04 \
}

// Output layer, four hidden activations into three class nodes
`define OUT_W { \
	32'h12_16_F8_FA, \
	32'h0A_F8_1A_F4, \
	32'hF0_08_F6_18 \
}

// Biases of class nodes 2 down to 0
`define OUT_B { \
	8'h00, \
	8'hFE, \
	8'h01 \
}

`endif

// ==== mlp_pkg.sv ====
`include "mlp_defines.svh"

package mlp_pkg;

	// Feature or activation word
	typedef logic signed [`DATA_W-1:0] dataT;

	// Fixed weight or bias
	typedef logic signed [`WEIGHT_W-1:0] weightT;

	// Full-precision product of one feature and one weight
	typedef logic signed [`PROD_W-1:0] prodT;

	// Sum of all products and the scaled bias of one node
	typedef logic signed [`ACC_W-1:0] accT;

	// Winning class number
	typedef logic [$clog2(`N_OUT)-1:0] classT;

endpackage

// ==== neuronNode.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"

// One perceptron node with three register stages for the input capture,
// the weighted sum and the scaled and rectified activation
module neuronNode #(
	parameter int nIn = `N_IN,
	parameter logic [nIn*`WEIGHT_W-1:0] weights = '0,
	parameter logic [`WEIGHT_W-1:0] bias = '0
)
(
	input logic clk,
	input logic reset,
	input mlp_pkg::dataT [nIn-1:0] in,
	output mlp_pkg::dataT act
);

	// The bias is moved onto the binary point of the products
	localparam mlp_pkg::accT biasScaled =
		mlp_pkg::accT'(mlp_pkg::weightT'(bias)) <<< `FRAC_BITS;

	mlp_pkg::dataT [nIn-1:0] inReg;
	mlp_pkg::prodT [nIn-1:0] prods;
	mlp_pkg::accT sumNext;
	mlp_pkg::accT sumReg;
	mlp_pkg::accT scaled;

	function automatic mlp_pkg::weightT weightAt(input int idx);
		return mlp_pkg::weightT'(weights[idx*`WEIGHT_W +: `WEIGHT_W]);
	endfunction

	// ReLU with an upper clamp so the result fits an activation word
	function automatic mlp_pkg::dataT relu(input mlp_pkg::accT value);
		if (value < 0)
			return '0;
		else if (value > `ACT_MAX)
			return mlp_pkg::dataT'(`ACT_MAX);
		else
			return mlp_pkg::dataT'(value[`DATA_W-1:0]);
	endfunction

	// Stage 1
	always_ff @(posedge clk)
	begin
		if (reset)
			inReg <= '0;
		else
			inReg <= in;
	end

	// Both operands are widened first, so the product is exact
	always_comb
	begin
		for (int i = 0; i < nIn; i++)
			prods[i] = mlp_pkg::prodT'(inReg[i]) * mlp_pkg::prodT'(weightAt(i));
	end

	always_comb
	begin
		sumNext = biasScaled;
		for (int i = 0; i < nIn; i++)
			sumNext = sumNext + mlp_pkg::accT'(prods[i]);
	end

	assign scaled = sumReg >>> `FRAC_BITS;  // Arithmetic shift keeps the sign

	// Stage 2 holds the sum, stage 3 the activation
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			act <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			act <= relu(scaled);
		end
	end

endmodule

// ==== denseLayer.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"

// Fully connected layer of neuronNode instances
module denseLayer #(
	parameter int nIn = `N_IN,
	parameter int nOut = `N_HID,
	parameter logic [nOut*nIn*`WEIGHT_W-1:0] weights = '0,
	parameter logic [nOut*`WEIGHT_W-1:0] bias = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlp_pkg::dataT [nIn-1:0] in,
	output logic outValid,
	output mlp_pkg::dataT [nOut-1:0] out
);

	localparam int nodeBits = nIn * `WEIGHT_W;  // Weight bits of one node

	logic [`NODE_LAT-1:0] validPipe;

	// The valid bit walks alongside the node pipeline
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[`NODE_LAT-2:0], inValid};
	end

	assign outValid = validPipe[`NODE_LAT-1];

	// Every node sees the whole input vector and gets its own weight slice
	for (genvar j = 0; j < nOut; j++)
	begin : genNode
		neuronNode #(
			.nIn(nIn),
			.weights(weights[j*nodeBits +: nodeBits]),
			.bias(bias[j*`WEIGHT_W +: `WEIGHT_W])
		)
		node (
			.clk(clk),
			.reset(reset),
			.in(in),
			.act(out[j])
		);
	end

endmodule

// ==== argmaxSelect.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"

// Picks the largest activation and registers it with its index
module argmaxSelect #(
	parameter int nIn = `N_OUT
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlp_pkg::dataT [nIn-1:0] acts,
	output logic outValid,
	output mlp_pkg::classT classIdx,
	output mlp_pkg::dataT classScore,
	output mlp_pkg::dataT [nIn-1:0] scores
);

	mlp_pkg::classT bestIdx;
	mlp_pkg::dataT bestVal;

	// A strict compare lets the lower index keep a tie
	always_comb
	begin
		bestIdx = '0;
		bestVal = acts[0];
		for (int i = 1; i < nIn; i++)
		begin
			if (acts[i] > bestVal)
			begin
				bestIdx = mlp_pkg::classT'(i);
				bestVal = acts[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	// Results only change on a valid vector, so they stay at zero until the first one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIdx <= '0;
			classScore <= '0;
			scores <= '0;
		end
		else if (inValid)
		begin
			classIdx <= bestIdx;
			classScore <= bestVal;
			scores <= acts;
		end
	end

endmodule

// ==== mlpClassifier.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"
`include "mlp_weights.svh"

// Two-layer perceptron classifier
// A vector strobed in with inValid comes out TOTAL_LAT cycles later
module mlpClassifier (
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlp_pkg::dataT [`N_IN-1:0] features,
	output logic outValid,
	output mlp_pkg::classT classIdx,
	output mlp_pkg::dataT classScore,
	output mlp_pkg::dataT [`N_OUT-1:0] scores
);

	mlp_pkg::dataT [`N_HID-1:0] hidActs;
	logic hidValid;
	mlp_pkg::dataT [`N_OUT-1:0] outActs;
	logic outLayerValid;

	denseLayer #(
		.nIn(`N_IN),
		.nOut(`N_HID),
		.weights(`HID_W),
		.bias(`HID_B)
	)
	hidLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.in(features),
		.outValid(hidValid),
		.out(hidActs)
	);

	// Class scores
	denseLayer #(
		.nIn(`N_HID),
		.nOut(`N_OUT),
		.weights(`OUT_W),
		.bias(`OUT_B)
	)
	outLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hidValid),
		.in(hidActs),
		.outValid(outLayerValid),
		.out(outActs)
	);

	argmaxSelect #(
		.nIn(`N_OUT)
	)
	argmax (
		.clk(clk),
		.reset(reset),
		.inValid(outLayerValid),
		.acts(outActs),
		.outValid(outValid),
		.classIdx(classIdx),
		.classScore(classScore),
		.scores(scores)  // Registered copy lines up with outValid
	);

endmodule

// ==== mlp_assertions.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"

// Port-level protocol checks for mlpClassifier
module mlp_assertions (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input mlp_pkg::classT classIdx,
	input mlp_pkg::dataT classScore,
	input mlp_pkg::dataT [`N_OUT-1:0] scores
);

	int unsigned cyclesUp;  // Counts edges since reset was released and stops at TOTAL_LAT

	always_ff @(posedge clk)
	begin
		if (reset)
			cyclesUp <= 0;
		else if (cyclesUp < `TOTAL_LAT)
			cyclesUp <= cyclesUp + 1;
	end

	// Each pulse matches a strobe TOTAL_LAT edges earlier, and each strobe gets a pulse
	latencyMatch: assert property (@(posedge clk) disable iff (reset)
		cyclesUp >= `TOTAL_LAT |-> outValid == $past(inValid, `TOTAL_LAT))
		else $error("outValid does not follow inValid by %0d cycles", `TOTAL_LAT);

	scoreConsistent: assert property (@(posedge clk) disable iff (reset)
		!classScore[`DATA_W-1] && classScore == scores[classIdx])
		else $error("classScore is negative or differs from the score at classIdx");

	// The first edge of reset may still see the power-up value
	idleInReset: assert property (@(posedge clk)
		reset && $past(reset) |-> !outValid)
		else $error("outValid is high while reset is held");

endmodule

// ==== mlp_tb.sv ====
`timescale 1ns/1ps
`include "mlp_defines.svh"
`include "mlp_weights.svh"

module mlp_tb;

	localparam int nDirected = 12;
	localparam int nRandom = 20;
	localparam int nRows = nDirected + nRandom;
	localparam int clkPeriod = 10;
	localparam int timeoutNs = (nRows + `TOTAL_LAT + 20) * clkPeriod * 4;

	localparam logic [`N_HID*`N_IN*`WEIGHT_W-1:0] hidW = `HID_W;
	localparam logic [`N_HID*`WEIGHT_W-1:0] hidB = `HID_B;
	localparam logic [`N_OUT*`N_HID*`WEIGHT_W-1:0] outW = `OUT_W;
	localparam logic [`N_OUT*`WEIGHT_W-1:0] outB = `OUT_B;

	logic clk;
	logic reset;
	logic inValid;
	mlp_pkg::dataT [`N_IN-1:0] features;
	logic outValid;
	mlp_pkg::classT classIdx;
	mlp_pkg::dataT classScore;
	mlp_pkg::dataT [`N_OUT-1:0] scores;

	// Stimulus table with the expected response of every row
	mlp_pkg::dataT [`N_IN-1:0] featTab [nRows];
	mlp_pkg::dataT [`N_OUT-1:0] expScores [nRows];
	mlp_pkg::classT expIdx [nRows];

	int rowQ [$];  // Rows in flight with the oldest first
	int startQ [$];
	int cycle = 0;
	int results = 0;
	int valueErrors = 0;
	int protocolErrors = 0;
	logic [31:0] lfsr;

	mlpClassifier dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.features(features),
		.outValid(outValid),
		.classIdx(classIdx),
		.classScore(classScore),
		.scores(scores)
	);

	bind mlpClassifier mlp_assertions sva (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.outValid(outValid),
		.classIdx(classIdx),
		.classScore(classScore),
		.scores(scores)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 32'h8020_0003;
		return outBit;
	endfunction

	function automatic mlp_pkg::dataT randomWord();
		mlp_pkg::dataT w;
		for (int b = 0; b < `DATA_W; b++)
			w[b] = lfsrBit();
		return w;
	endfunction

	function automatic int signedByte(input logic [511:0] vec, input int idx);
		return int'(signed'(vec[idx*`WEIGHT_W +: `WEIGHT_W]));
	endfunction

	// Drop the fraction bits, then clamp into 0 .. ACT_MAX
	function automatic int activation(input int sum);
		int shifted;
		shifted = sum >>> `FRAC_BITS;
		if (shifted < 0)
			return 0;
		if (shifted > `ACT_MAX)
			return `ACT_MAX;
		return shifted;
	endfunction

	function automatic int directedValue(input int r, input int i);
		case (r)
			0: return 0;
			1: return 127;
			2: return -128;
			3: return (i % 2 == 0) ? 100 : -100;
			4: return (i % 2 == 0) ? -100 : 100;
			5: return (i < 5) ? 120 : ((i < 9) ? -120 : 0);  // Leans to class 0
			6: return (i >= 2 && i <= 7) ? 120 : -120;  // Leans to class 1
			7: return (i == 6 || i == 8 || i == 9) ? 120 : ((i == 1 || i == 3) ? -120 : 0);
			8: return i * 20 - 90;
			9: return (i == `N_IN - 1) ? 127 : 0;
			10: return (i % 2 == 0) ? 3 : -2;
			default: return 90 - i * 20;
		endcase
	endfunction

	function automatic void modelRow(input int r);
		int hid [`N_HID];
		int cls [`N_OUT];
		int sum;
		int best;
		for (int j = 0; j < `N_HID; j++)
		begin
			sum = signedByte(512'(hidB), j) * (1 << `FRAC_BITS);
			for (int i = 0; i < `N_IN; i++)
				sum += int'(featTab[r][i]) * signedByte(512'(hidW), j * `N_IN + i);
			hid[j] = activation(sum);
		end
		for (int k = 0; k < `N_OUT; k++)
		begin
			sum = signedByte(512'(outB), k) * (1 << `FRAC_BITS);
			for (int j = 0; j < `N_HID; j++)
				sum += hid[j] * signedByte(512'(outW), k * `N_HID + j);
			cls[k] = activation(sum);
			expScores[r][k] = mlp_pkg::dataT'(cls[k]);
		end
		best = 0;
		for (int k = 1; k < `N_OUT; k++)
			if (cls[k] > cls[best])
				best = k;  // Only a strictly larger score wins, so a tie keeps the lower class
		expIdx[r] = mlp_pkg::classT'(best);
	endfunction

	task automatic checkResult();
		int r;
		int start;
		if (rowQ.size() == 0)
		begin
			$display("Unexpected outValid at %0t with no vector in flight", $time);
			protocolErrors++;
			return;
		end
		r = rowQ.pop_front();
		start = (startQ.size() != 0) ? startQ.pop_front() : cycle;
		if (cycle - start != `TOTAL_LAT)
		begin
			$display("** Error at %0t: row %0d took %0d cycles, expected %0d",
				$time, r, cycle - start, `TOTAL_LAT);
			protocolErrors++;
		end
		for (int k = 0; k < `N_OUT; k++)
		begin
			if (scores[k] != expScores[r][k])
			begin
				$display("** Error at %0t: row %0d score %0d is %0d, expected %0d",
					$time, r, k, scores[k], expScores[r][k]);
				valueErrors++;
			end
		end
		if (classIdx != expIdx[r])
		begin
			$display("** Error at %0t: row %0d class is %0d, expected %0d",
				$time, r, classIdx, expIdx[r]);
			valueErrors++;
		end
		if (classScore != expScores[r][expIdx[r]])
		begin
			$display("** Error at %0t: row %0d class score is %0d, expected %0d",
				$time, r, classScore, expScores[r][expIdx[r]]);
			valueErrors++;
		end
		results++;
	endtask

	// Outputs hold their reset value until the first result
	task automatic checkIdle();
		if (classIdx != '0 || classScore != '0 || scores != '0)
		begin
			$display("** Error at %0t: outputs not zero before the first result", $time);
			valueErrors++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Samples are the values from just before the edge
	always @(posedge clk)
	begin
		if (inValid)
			startQ.push_back(cycle);
		if (outValid)
			checkResult();
		else if (results == 0 && cycle > 0)
			checkIdle();
		cycle++;
	end

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;
		lfsr = 32'hf8b2;
		for (int r = 0; r < nRows; r++)
		begin
			for (int i = 0; i < `N_IN; i++)
				featTab[r][i] = (r < nDirected) ? mlp_pkg::dataT'(directedValue(r, i))
					: randomWord();
			modelRow(r);
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Directed rows get gaps of 0 to 2 cycles while random rows run back to back
		for (int r = 0; r < nRows; r++)
		begin
			@(posedge clk);
			inValid <= 1'b1;
			features <= featTab[r];
			rowQ.push_back(r);
			repeat ((r < nDirected) ? r % 3 : 0)
			begin
				@(posedge clk);
				inValid <= 1'b0;
			end
		end
		@(posedge clk);
		inValid <= 1'b0;
		features <= '0;

		while (rowQ.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk);  // A stray extra pulse would show up here

		$display("Results %0d of %0d, value errors %0d, protocol errors %0d",
			results, nRows, valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		#(timeoutNs);
		$display("Timeout after %0d ns: only %0d of %0d results arrived",
			timeoutNs, results, nRows);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
mlp_pkg.sv
neuronNode.sv
denseLayer.sv
argmaxSelect.sv
mlpClassifier.sv
mlp_assertions.sv
mlp_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the classifier testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mlp_tb -f vlog.f \
	> build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vmlp_tb > sim.log 2>&1
cat sim.log

grep -q "^Test OK$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
